// File: src/spmd_params.svh
`ifndef SPMD_PARAMS_SVH
`define SPMD_PARAMS_SVH

// mesh shape
`define NUM_ROWS 2
`define NUM_COLS 2
`define NUM_TILES (`NUM_ROWS * `NUM_COLS)

// program image, loaded into every tile
`define MEM_SIZE_BYTES 64
`define MEM_WORDS 16 // MEM_SIZE_BYTES / 4

`define DATA_WIDTH 32
`define ADDR_WIDTH 12 // byte address width

// byte address of the word patched with the tile number
`define TILE_ID_PTR 8

// coordinate widths for a 2x2 mesh
`define X_WIDTH 1
`define Y_WIDTH 1

`endif

// File: src/mc_noc_pkg.sv
`include "spmd_params.svh"

package mc_noc_pkg;

  // tile coordinates
  typedef logic [`X_WIDTH-1:0] x_cord_t;
  typedef logic [`Y_WIDTH-1:0] y_cord_t;

  // network opcodes
  typedef enum logic [1:0]
  {
    op_store = 2'd1, // write a word into instruction memory
    op_cfg   = 2'd2  // write a tile control register
  } mc_op_e;

  // control register word addresses for op_cfg
  typedef enum logic [`ADDR_WIDTH-3:0]
  {
    cfg_freeze = 0,
    cfg_arb    = 1
  } cfg_reg_e;

  // request packet, 46 bits for the default sizes
  typedef struct packed
  {
    mc_op_e                  op;
    logic [`ADDR_WIDTH-3:0]  addr;   // word address
    logic [`DATA_WIDTH-1:0]  data;
    x_cord_t                 x_cord;
    y_cord_t                 y_cord;
  } mc_packet_s;

endpackage

// File: src/spmd_loader_pkg.sv
package spmd_loader_pkg;

  // loader sequence
  // store image words into every tile, then clear the freeze bits,
  // then put the arbiters in static mode, then stop
  typedef enum logic [1:0]
  {
    ph_load,     // op_store of the image, tile by tile
    ph_unfreeze, // op_cfg to cfg_freeze
    ph_arb_cfg,  // op_cfg to cfg_arb
    ph_done      // nothing left to send
  } loader_phase_e;

endpackage

// File: src/program_rom.sv
`timescale 1ns/10ps

`include "spmd_params.svh"

module program_rom
  (
    input  logic [$clog2(`MEM_WORDS)-1:0] rd_addr_i, // word address
    output logic [`DATA_WIDTH-1:0]        rd_data_o
  );

  logic [`DATA_WIDTH-1:0] rom [`MEM_WORDS];

  // image shared by every tile
  initial
  begin
    $readmemh("src/program.hex", rom);
  end

  assign rd_data_o = rom[rd_addr_i]; // async read in the same cycle

endmodule

// File: src/spmd_loader.sv
`timescale 1ns/10ps

`include "spmd_params.svh"

module spmd_loader
  (
    input  logic                          clk_i,
    input  logic                          reset_i,
    output logic [$clog2(`MEM_WORDS)-1:0] rom_addr_o,
    input  logic [`DATA_WIDTH-1:0]        rom_data_i,
    output mc_noc_pkg::mc_packet_s        pkt_o,
    output logic                          pkt_v_o,
    input  logic                          pkt_ready_i,
    input  logic                          link_empty_i,
    output logic                          done_o
  );

  import mc_noc_pkg::*;
  import spmd_loader_pkg::*;

  localparam int TILE_W = $clog2(`NUM_TILES);
  localparam int WORD_W = $clog2(`MEM_WORDS);
  localparam logic [WORD_W-1:0] ID_WORD = WORD_W'(`TILE_ID_PTR / 4);

  loader_phase_e      phase_r, phase_n;
  logic [TILE_W-1:0]  tile_r, tile_n;
  logic [WORD_W-1:0]  word_r, word_n;
  logic               v_r;
  logic               xfer;
  logic               tile_last;
  logic               word_last;
  x_cord_t            x_cord;
  y_cord_t            y_cord;

  assign xfer      = v_r & pkt_ready_i;
  assign tile_last = (tile_r == TILE_W'(`NUM_TILES - 1));
  assign word_last = (word_r == WORD_W'(`MEM_WORDS - 1));

  // linear tile number to mesh position, row major
  assign x_cord = x_cord_t'(tile_r % `NUM_COLS);
  assign y_cord = y_cord_t'(tile_r / `NUM_COLS);

  assign rom_addr_o = word_r;
  assign pkt_v_o    = v_r;
  assign done_o     = (phase_r == ph_done) & link_empty_i; // last write has left the link

  // counters move only when the link takes the packet
  always_comb
  begin
    phase_n = phase_r;
    tile_n  = tile_r;
    word_n  = word_r;
    if (xfer)
    begin
      case (phase_r)
        ph_load:
        begin
          word_n = word_r + 1'b1; // wraps after the last word
          if (word_last)
          begin
            tile_n = tile_last ? '0 : tile_r + 1'b1;
            if (tile_last)
              phase_n = ph_unfreeze;
          end
        end
        ph_unfreeze:
        begin
          tile_n = tile_last ? '0 : tile_r + 1'b1;
          if (tile_last)
            phase_n = ph_arb_cfg;
        end
        ph_arb_cfg:
        begin
          tile_n = tile_last ? '0 : tile_r + 1'b1;
          if (tile_last)
            phase_n = ph_done;
        end
        default: ;
      endcase
    end
  end

  always_ff @(posedge clk_i)
  begin
    if (reset_i)
    begin
      phase_r <= ph_load;
      tile_r  <= '0;
      word_r  <= '0;
      v_r     <= 1'b0;
    end
    else
    begin
      phase_r <= phase_n;
      tile_r  <= tile_n;
      word_r  <= word_n;
      v_r     <= (phase_n != ph_done);
    end
  end

  // packet follows the counters, so it holds until taken
  always_comb
  begin
    pkt_o.x_cord = x_cord;
    pkt_o.y_cord = y_cord;
    case (phase_r)
      ph_load:
      begin
        pkt_o.op   = op_store;
        pkt_o.addr = (`ADDR_WIDTH-2)'(word_r);
        // each tile's copy carries its own id at the tile-id word
        pkt_o.data = (word_r == ID_WORD) ? `DATA_WIDTH'(tile_r) : rom_data_i;
      end
      ph_unfreeze:
      begin
        pkt_o.op   = op_cfg;
        pkt_o.addr = cfg_freeze;
        pkt_o.data = '0; // release the core
      end
      default:
      begin
        pkt_o.op   = op_cfg;
        pkt_o.addr = cfg_arb;
        pkt_o.data = '0; // static arbitration
      end
    endcase
  end

endmodule

// File: src/noc_link_fifo.sv
`timescale 1ns/10ps

module noc_link_fifo
  (
    input  logic                   clk_i,
    input  logic                   reset_i,
    input  mc_noc_pkg::mc_packet_s in_pkt_i,
    input  logic                   in_v_i,
    output logic                   ready_o,
    output mc_noc_pkg::mc_packet_s out_pkt_o,
    output logic                   out_v_o,
    input  logic                   out_ready_i,
    output logic                   empty_o
  );

  import mc_noc_pkg::*;

  mc_packet_s  buf_r [2];
  logic        wr_ptr_r;
  logic        rd_ptr_r;
  logic [1:0]  count_r;
  logic        push;
  logic        pop;

  assign ready_o = (count_r != 2'd2); // accept while not full
  assign out_v_o = (count_r != 2'd0);
  assign empty_o = (count_r == 2'd0);

  assign push = in_v_i & ready_o;
  assign pop  = out_v_o & out_ready_i;

  assign out_pkt_o = buf_r[rd_ptr_r]; // head entry

  always_ff @(posedge clk_i)
  begin
    if (push)
      buf_r[wr_ptr_r] <= in_pkt_i;
  end

  always_ff @(posedge clk_i)
  begin
    if (reset_i)
    begin
      wr_ptr_r <= 1'b0;
      rd_ptr_r <= 1'b0;
      count_r  <= 2'd0;
    end
    else
    begin
      if (push)
        wr_ptr_r <= ~wr_ptr_r;
      if (pop)
        rd_ptr_r <= ~rd_ptr_r;
      case ({push, pop})
        2'b10:   count_r <= count_r + 2'd1;
        2'b01:   count_r <= count_r - 2'd1;
        default: count_r <= count_r; // both or neither
      endcase
    end
  end

endmodule

// File: src/tile_array.sv
`timescale 1ns/10ps

`include "spmd_params.svh"

module tile_array
  (
    input  logic                          clk_i,
    input  logic                          reset_i,
    input  mc_noc_pkg::mc_packet_s        pkt_i,
    input  logic                          v_i,
    input  logic                          stall_i,   // network congestion
    output logic                          ready_o,
    output logic [`NUM_TILES-1:0]         frozen_o,
    output logic [`NUM_TILES-1:0]         arb_dynamic_o,
    input  logic [$clog2(`NUM_TILES)-1:0] rd_tile_i,
    input  logic [$clog2(`MEM_WORDS)-1:0] rd_word_i,
    output logic [`DATA_WIDTH-1:0]        rd_data_o
  );

  import mc_noc_pkg::*;

  localparam int TILE_W = $clog2(`NUM_TILES);
  localparam int WORD_W = $clog2(`MEM_WORDS);

  // all instruction memories back to back, tile-major
  logic [`DATA_WIDTH-1:0] imem_r [`NUM_TILES * `MEM_WORDS];
  logic [`NUM_TILES-1:0]  frozen_r;
  logic [`NUM_TILES-1:0]  arb_dyn_r;
  logic [TILE_W-1:0]      dst_tile;
  logic [WORD_W-1:0]      dst_word;
  logic                   we;

  assign ready_o = ~stall_i;
  assign we      = v_i & ~stall_i;

  // destination tile from its mesh coordinates
  assign dst_tile = TILE_W'(pkt_i.y_cord * `NUM_COLS + pkt_i.x_cord);
  assign dst_word = pkt_i.addr[WORD_W-1:0];

  always_ff @(posedge clk_i)
  begin
    if (we && pkt_i.op == op_store)
      imem_r[{dst_tile, dst_word}] <= pkt_i.data;
  end

  always_ff @(posedge clk_i)
  begin
    if (reset_i)
    begin
      frozen_r  <= '1; // cores held until the image is in
      arb_dyn_r <= '1;
    end
    else if (we && pkt_i.op == op_cfg)
    begin
      case (cfg_reg_e'(pkt_i.addr))
        cfg_freeze: frozen_r[dst_tile]  <= pkt_i.data[0];
        cfg_arb:    arb_dyn_r[dst_tile] <= pkt_i.data[0];
        default: ; // unknown registers are ignored
      endcase
    end
  end

  assign frozen_o      = frozen_r;
  assign arb_dynamic_o = arb_dyn_r;

  // readback port for checking
  assign rd_data_o = imem_r[{rd_tile_i, rd_word_i}];

endmodule

// File: src/spmd_subsystem.sv
`timescale 1ns/10ps

`include "spmd_params.svh"

module spmd_subsystem
  (
    input  logic                          clk_i,
    input  logic                          reset_i,
    input  logic                          stall_i,
    input  logic [$clog2(`NUM_TILES)-1:0] rd_tile_i,
    input  logic [$clog2(`MEM_WORDS)-1:0] rd_word_i,
    output logic [`DATA_WIDTH-1:0]        rd_data_o,
    output logic [`NUM_TILES-1:0]         frozen_o,
    output logic [`NUM_TILES-1:0]         arb_dynamic_o,
    output logic                          done_o
  );

  import mc_noc_pkg::*;

  logic [$clog2(`MEM_WORDS)-1:0] rom_addr;
  logic [`DATA_WIDTH-1:0]        rom_data;
  mc_packet_s                    ld_pkt;    // loader to link
  logic                          ld_v;
  logic                          link_ready;
  mc_packet_s                    link_pkt;  // link to mesh
  logic                          link_v;
  logic                          mesh_ready;
  logic                          link_empty;

  program_rom program_rom_inst
    (
      .rd_addr_i (rom_addr),
      .rd_data_o (rom_data)
    );

  spmd_loader spmd_loader_inst
    (
      .clk_i        (clk_i),
      .reset_i      (reset_i),
      .rom_addr_o   (rom_addr),
      .rom_data_i   (rom_data),
      .pkt_o        (ld_pkt),
      .pkt_v_o      (ld_v),
      .pkt_ready_i  (link_ready),
      .link_empty_i (link_empty),
      .done_o       (done_o)
    );

  noc_link_fifo noc_link_fifo_inst
    (
      .clk_i       (clk_i),
      .reset_i     (reset_i),
      .in_pkt_i    (ld_pkt),
      .in_v_i      (ld_v),
      .ready_o     (link_ready),
      .out_pkt_o   (link_pkt),
      .out_v_o     (link_v),
      .out_ready_i (mesh_ready),
      .empty_o     (link_empty)
    );

  tile_array tile_array_inst
    (
      .clk_i         (clk_i),
      .reset_i       (reset_i),
      .pkt_i         (link_pkt),
      .v_i           (link_v),
      .stall_i       (stall_i),
      .ready_o       (mesh_ready),
      .frozen_o      (frozen_o),
      .arb_dynamic_o (arb_dynamic_o),
      .rd_tile_i     (rd_tile_i),
      .rd_word_i     (rd_word_i),
      .rd_data_o     (rd_data_o)
    );

endmodule

// File: test/spmd_subsystem_sva.sv
`timescale 1ns/10ps

module spmd_loader_sva
  (
    input  logic                           clk_i,
    input  logic                           reset_i,
    input  mc_noc_pkg::mc_packet_s         pkt_i,
    input  logic                           pkt_v_i,
    input  logic                           pkt_ready_i,
    input  spmd_loader_pkg::loader_phase_e phase_i
  );

  import spmd_loader_pkg::*;

  int fail_cnt = 0; // assertion failures so far

  // nothing left to send once the sequence is over
  no_valid_when_done: assert property (@(posedge clk_i) disable iff (reset_i)
    (phase_i == ph_done) |-> !pkt_v_i)
  else
  begin
    fail_cnt++;
    $error("loader packet valid in the done phase");
  end

  // a packet waiting for the link must not change
  pkt_held_while_stalled: assert property (@(posedge clk_i) disable iff (reset_i)
    (pkt_v_i && !pkt_ready_i) |=> $stable(pkt_i))
  else
  begin
    fail_cnt++;
    $error("loader packet changed while waiting for ready");
  end

  no_return_to_load: assert property (@(posedge clk_i) disable iff (reset_i)
    (phase_i != ph_load) |=> (phase_i != ph_load))
  else
  begin
    fail_cnt++;
    $error("loader went back to the load phase without a reset");
  end

endmodule

bind spmd_loader spmd_loader_sva spmd_loader_sva_inst
  (
    .clk_i       (clk_i),
    .reset_i     (reset_i),
    .pkt_i       (pkt_o),
    .pkt_v_i     (pkt_v_o),
    .pkt_ready_i (pkt_ready_i),
    .phase_i     (phase_r)
  );

// File: test/spmd_subsystem_tb.sv
`timescale 1ns/10ps

`include "spmd_params.svh"

module spmd_subsystem_tb;

  localparam int TILE_W      = $clog2(`NUM_TILES);
  localparam int WORD_W      = $clog2(`MEM_WORDS);
  localparam int NUM_PKTS    = `NUM_TILES * (`MEM_WORDS + 2); // stores plus two config rounds
  localparam int DONE_LIMIT  = NUM_PKTS * 4 + 200;
  localparam int DONE_CYCLES = 74;  // 72 transfers plus one fill and one drain cycle
  localparam int NUM_ENTRIES = 16;
  localparam logic STALL_OFF    = 1'b0;
  localparam logic STALL_RANDOM = 1'b1;

  typedef struct packed
  {
    logic [TILE_W-1:0] tile;
    logic [WORD_W-1:0] word;
    logic              mode; // stall mode of the boot before the readback
  } entry_t;

  logic                   clk_i;
  logic                   reset_i;
  logic                   stall_i;
  logic [TILE_W-1:0]      rd_tile_i;
  logic [WORD_W-1:0]      rd_word_i;
  logic [`DATA_WIDTH-1:0] rd_data_o;
  logic [`NUM_TILES-1:0]  frozen_o;
  logic [`NUM_TILES-1:0]  arb_dynamic_o;
  logic                   done_o;

  logic [`DATA_WIDTH-1:0] image [`MEM_WORDS]; // reference copy of the program
  int                     seed_ret;

  // word 2 is the tile-id word in every tile
  entry_t tbl [NUM_ENTRIES] = '{
    {2'd0, 4'd0,  STALL_OFF},
    {2'd0, 4'd2,  STALL_OFF},
    {2'd1, 4'd2,  STALL_OFF},
    {2'd2, 4'd2,  STALL_OFF},
    {2'd3, 4'd2,  STALL_OFF},
    {2'd1, 4'd5,  STALL_OFF},
    {2'd2, 4'd15, STALL_OFF},
    {2'd3, 4'd9,  STALL_OFF},
    {2'd3, 4'd2,  STALL_RANDOM},
    {2'd2, 4'd2,  STALL_RANDOM},
    {2'd1, 4'd2,  STALL_RANDOM},
    {2'd0, 4'd2,  STALL_RANDOM},
    {2'd0, 4'd15, STALL_RANDOM},
    {2'd1, 4'd7,  STALL_RANDOM},
    {2'd2, 4'd1,  STALL_RANDOM},
    {2'd3, 4'd0,  STALL_RANDOM}
  };

  spmd_subsystem spmd_subsystem_inst
    (
      .clk_i         (clk_i),
      .reset_i       (reset_i),
      .stall_i       (stall_i),
      .rd_tile_i     (rd_tile_i),
      .rd_word_i     (rd_word_i),
      .rd_data_o     (rd_data_o),
      .frozen_o      (frozen_o),
      .arb_dynamic_o (arb_dynamic_o),
      .done_o        (done_o)
    );

  always #10 clk_i = ~clk_i;

  function automatic logic [`DATA_WIDTH-1:0] expected_word(int tile, int word);
    if (word == `TILE_ID_PTR / 4)
      return `DATA_WIDTH'(tile); // each copy carries its own tile number
    return image[word];
  endfunction

  task automatic report_failure(string msg);
    $display("%s", msg);
    $display("sim failed");
    $fatal(1, "run stopped at the first error");
  endtask

  task automatic check_reset_state(string when);
    assert (done_o === 1'b0 && frozen_o === '1 && arb_dynamic_o === '1)
    else report_failure($sformatf("MISMATCH at %0t ns: %s done %b frozen %b arb %b",
                                  $time, when, done_o, frozen_o, arb_dynamic_o));
  endtask

  task automatic apply_reset();
    reset_i = 1'b1;
    stall_i = 1'b0;
    repeat (8)
    begin
      @(posedge clk_i);
      #2;
      check_reset_state("during reset");
    end
    reset_i = 1'b0;
  endtask

  // count cycles from reset release until done, with random stalls if asked
  task automatic wait_done(input logic mode, output int cycles);
    cycles = 0;
    do
    begin
      @(posedge clk_i);
      #2;
      cycles++;
      if (mode == STALL_RANDOM)
        stall_i = ($urandom % 3 == 0); // congested one cycle in three
      if (cycles == 1)
        check_reset_state("after reset");
      if (cycles >= DONE_LIMIT)
        report_failure($sformatf("timeout: done_o did not rise within %0d cycles",
                                 DONE_LIMIT));
    end
    while (done_o !== 1'b1);
    stall_i = 1'b0;
  endtask

  task automatic run_boot(input logic mode);
    int cycles;
    apply_reset();
    wait_done(mode, cycles);
    if (mode == STALL_OFF)
    begin
      assert (cycles == DONE_CYCLES)
      else report_failure($sformatf("MISMATCH at %0t ns: done after %0d cycles, expected %0d",
                                    $time, cycles, DONE_CYCLES));
    end
    // every tile released and set to static arbitration
    assert (frozen_o === '0 && arb_dynamic_o === '0)
    else report_failure($sformatf("MISMATCH at %0t ns: final frozen %b arb %b, expected all 0",
                                  $time, frozen_o, arb_dynamic_o));
  endtask

  task automatic check_word(input entry_t e);
    logic [`DATA_WIDTH-1:0] exp;
    @(posedge clk_i);
    #2;
    rd_tile_i = e.tile;
    rd_word_i = e.word;
    exp = expected_word(e.tile, e.word);
    @(posedge clk_i);
    #2; // address held for a whole cycle
    assert (rd_data_o === exp)
    else report_failure($sformatf("MISMATCH at %0t ns: tile %0d word %0d read %h, expected %h",
                                  $time, e.tile, e.word, rd_data_o, exp));
  endtask

  initial
  begin
    seed_ret  = $urandom(8);
    clk_i     = 1'b0;
    reset_i   = 1'b1;
    stall_i   = 1'b0;
    rd_tile_i = '0;
    rd_word_i = '0;
    $readmemh("src/program.hex", image);

    for (int i = 0; i < NUM_ENTRIES; i++)
    begin
      // a change of stall mode starts a fresh boot from reset
      if (i == 0 || tbl[i].mode != tbl[i-1].mode)
        run_boot(tbl[i].mode);
      check_word(tbl[i]);
    end

    repeat (2) @(posedge clk_i);
    if (spmd_subsystem_inst.spmd_loader_inst.spmd_loader_sva_inst.fail_cnt == 0)
    begin
      $display("sim passed");
      $finish;
    end
    else
    begin
      $display("loader protocol assertions failed during the run");
      $display("sim failed");
      $fatal(1, "run ended with assertion failures");
    end
  end

endmodule

// File: files.f
+incdir+src
src/mc_noc_pkg.sv
src/spmd_loader_pkg.sv
src/program_rom.sv
src/spmd_loader.sv
src/noc_link_fifo.sv
src/tile_array.sv
src/spmd_subsystem.sv
test/spmd_subsystem_sva.sv
test/spmd_subsystem_tb.sv

// File: Bender.yml
package:
  name: spmd_subsystem

sources:
  - include_dirs:
      - src
    files:
      - src/mc_noc_pkg.sv
      - src/spmd_loader_pkg.sv
      - src/program_rom.sv
      - src/spmd_loader.sv
      - src/noc_link_fifo.sv
      - src/tile_array.sv
      - src/spmd_subsystem.sv
  - target: test
    include_dirs:
      - src
    files:
      - test/spmd_subsystem_sva.sv
      - test/spmd_subsystem_tb.sv

// File: src/program.hex
// one 32-bit instruction word per line, word address 0 to 15, word 2 holds the tile id
00000013
00100093
ffffffff
00812103
00110193
00218233
fe0212e3
00402283
00528333
00602023
0000006f
00000013
0ff00393
00739463
00000013
0000006f
